/* retire_macros.svh */
/*
  sizing and CSR map for the retirement subsystem
  RQ_DEPTH and SB_DEPTH must be powers of two, commit logic assumes two ports
*/
`ifndef RETIRE_MACROS_SVH
`define RETIRE_MACROS_SVH

// datapath width
`define XLEN 32
// retire bandwidth per cycle
`define NR_COMMIT_PORTS 2
// queue sizes
`define RQ_DEPTH 8
`define SB_DEPTH 4

// machine CSRs implemented by csr_unit
`define CSR_MSCRATCH 12'h340
`define CSR_MCAUSE 12'h342
`define CSR_MTVAL 12'h343

`endif

/* retire_pkg.sv */
/*
  instruction, exception and commit entry types
  entry exception fields are set upstream, the commit stage only reads them
*/
`include "retire_macros.svh"

package retire_pkg;

  // plain vectors with a fixed meaning
  typedef logic [`XLEN-1:0] xlen_t;
  typedef logic [4:0]       reg_addr_t;
  typedef logic [3:0]       trans_id_t;
  typedef logic [11:0]      csr_addr_t;

  // retired operation classes
  typedef enum logic [2:0] {
    OP_ALU,
    OP_LOAD,
    OP_STORE,
    OP_CSRRW,
    OP_FENCE
  } instr_op_t;

  typedef struct packed {
    logic  valid;
    xlen_t cause;
    xlen_t tval;
  } exception_t;

  // one completed instruction waiting for retirement
  typedef struct packed {
    instr_op_t  op;
    reg_addr_t  rd;
    trans_id_t  trans_id;
    // alu/load data, store data or csr write data
    xlen_t      result;
    // store address, csr address sits in bits 11:0
    xlen_t      addr;
    exception_t ex;
  } commit_entry_t;

  // committed store handed to the store buffer
  typedef struct packed {
    xlen_t addr;
    xlen_t data;
  } store_entry_t;

endpackage

/* wb_pkg.sv */
/*
  wishbone classic master signals, word writes only
*/
`include "retire_macros.svh"

package wb_pkg;

  typedef logic [31:0] wb_addr_t;

  // master to slave
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`XLEN/8-1:0]     sel;
    wb_addr_t               adr;
    logic [`XLEN-1:0]       dat;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic             ack;
    logic [`XLEN-1:0] dat;
  } wb_rsp_t;

endpackage

/* reorder_queue.sv */
/*
  in-order queue of completed instructions with two heads
  RQ_DEPTH must be a power of two, a dispatch during flush is dropped
*/
`include "retire_macros.svh"

module reorder_queue (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  logic                                              flush_i,
  input  logic                                              dispatch_valid_i,
  input  retire_pkg::commit_entry_t                         dispatch_entry_i,
  output logic                                              dispatch_ready_o,
  input  logic [`NR_COMMIT_PORTS-1:0]                       commit_ack_i,
  output logic [`NR_COMMIT_PORTS-1:0]                       head_valid_o,
  output retire_pkg::commit_entry_t [`NR_COMMIT_PORTS-1:0]  head_entry_o
);
  import retire_pkg::*;

  localparam int unsigned PTR_W = $clog2(`RQ_DEPTH);

  // storage, payload only
  commit_entry_t    mem_q [`RQ_DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_p1;
  logic [PTR_W:0]   count_q;
  logic             push;
  logic [1:0]       pop_cnt;

  // full queue holds off dispatch
  assign dispatch_ready_o = (count_q != `RQ_DEPTH);
  assign push             = dispatch_valid_i & dispatch_ready_o & ~flush_i;
  // ack 1 only ever comes with ack 0
  assign pop_cnt          = {1'b0, commit_ack_i[0]} + {1'b0, commit_ack_i[1]};

  // second head wraps with the pointer width
  assign rd_ptr_p1 = rd_ptr_q + 1'b1;

  assign head_valid_o[0] = (count_q != '0);
  assign head_valid_o[1] = (count_q > 1);
  assign head_entry_o[0] = mem_q[rd_ptr_q];
  assign head_entry_o[1] = mem_q[rd_ptr_p1];

  // ------------------------------
  // pointers and fill level
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // exception at the head, everything younger is discarded
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      rd_ptr_q <= rd_ptr_q + PTR_W'(pop_cnt);
      wr_ptr_q <= wr_ptr_q + PTR_W'(push);
      count_q  <= count_q + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop_cnt);
    end
  end

  // entry write
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= dispatch_entry_i;
    end
  end

endmodule

/* commit_stage.sv */
/*
  retires up to two entries per cycle, port 1 takes ALU and LOAD only
  purely combinational, exception_o doubles as the queue flush and trap record
*/
`include "retire_macros.svh"

module commit_stage (
  input  logic                                              clk_i,
  input  logic                                              halt_i,
  input  retire_pkg::commit_entry_t [`NR_COMMIT_PORTS-1:0]  commit_entry_i,
  input  logic [`NR_COMMIT_PORTS-1:0]                       commit_valid_i,
  output logic [`NR_COMMIT_PORTS-1:0]                       commit_ack_o,
  // register file
  output logic [`NR_COMMIT_PORTS-1:0]                       we_o,
  output retire_pkg::reg_addr_t [`NR_COMMIT_PORTS-1:0]      waddr_o,
  output retire_pkg::xlen_t [`NR_COMMIT_PORTS-1:0]          wdata_o,
  // csr unit
  output retire_pkg::csr_addr_t                             csr_addr_o,
  output retire_pkg::xlen_t                                 csr_wdata_o,
  output logic                                              csr_we_o,
  input  retire_pkg::xlen_t                                 csr_rdata_i,
  input  retire_pkg::exception_t                            csr_exception_i,
  // store buffer
  output logic                                              commit_lsu_o,
  output retire_pkg::store_entry_t                          store_o,
  input  logic                                              lsu_ready_i,
  input  logic                                              no_st_pending_i,
  output retire_pkg::exception_t                            exception_o,
  output retire_pkg::trans_id_t                             commit_tran_id_o
);
  import retire_pkg::*;

  // destination index straight from each head
  for (genvar i = 0; i < `NR_COMMIT_PORTS; i++) begin : gen_waddr
    assign waddr_o[i] = commit_entry_i[i].rd;
  end

  assign commit_tran_id_o = commit_entry_i[0].trans_id;

  // csr access always follows port 0, the write is gated below
  assign csr_addr_o  = commit_entry_i[0].addr[11:0];
  assign csr_wdata_o = commit_entry_i[0].result;

  assign store_o.addr = commit_entry_i[0].addr;
  assign store_o.data = commit_entry_i[0].result;

  // ------------------------------
  // exception selection
  // ------------------------------
  always_comb begin : exception_sel
    exception_o = '0;
    if (commit_valid_i[0] && !halt_i) begin
      if (commit_entry_i[0].ex.valid) begin
        // fault carried in the entry wins
        exception_o = commit_entry_i[0].ex;
      end else if (commit_entry_i[0].op == OP_CSRRW && csr_exception_i.valid) begin
        exception_o      = csr_exception_i;
        // tval comes from the entry, not from the csr unit
        exception_o.tval = commit_entry_i[0].ex.tval;
      end
    end
  end

  // ------------------------------
  // retirement
  // ------------------------------
  always_comb begin : commit
    commit_ack_o = '0;
    we_o         = '0;
    wdata_o[0]   = commit_entry_i[0].result;
    wdata_o[1]   = commit_entry_i[1].result;
    commit_lsu_o = 1'b0;
    csr_we_o     = 1'b0;

    // port 0, no retirement while halted or on a fault
    if (commit_valid_i[0] && !halt_i && !exception_o.valid) begin
      case (commit_entry_i[0].op)
        OP_ALU, OP_LOAD: begin
          commit_ack_o[0] = 1'b1;
          we_o[0]         = 1'b1;
        end
        OP_STORE: begin
          // stall on a full store buffer
          commit_ack_o[0] = lsu_ready_i;
          commit_lsu_o    = lsu_ready_i;
        end
        OP_CSRRW: begin
          // old csr value goes to rd
          commit_ack_o[0] = 1'b1;
          we_o[0]         = 1'b1;
          wdata_o[0]      = csr_rdata_i;
          csr_we_o        = 1'b1;
        end
        OP_FENCE: begin
          // wait until every older store reached memory
          commit_ack_o[0] = no_st_pending_i;
        end
        default: begin
          commit_ack_o[0] = 1'b0;
        end
      endcase
    end

    // port 1 rides along with simple ops only
    if (commit_ack_o[0] && commit_valid_i[1]
        && !(commit_entry_i[0].op inside {OP_CSRRW, OP_FENCE})
        && !commit_entry_i[1].ex.valid
        && (commit_entry_i[1].op inside {OP_ALU, OP_LOAD})) begin
      commit_ack_o[1] = 1'b1;
      we_o[1]         = 1'b1;
    end
  end

endmodule

/* reg_file.sv */
/*
  31 general registers, x0 reads zero, combinational read
  on a same-address write port 1 lands last
*/
`include "retire_macros.svh"

module reg_file (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  logic [`NR_COMMIT_PORTS-1:0]                   we_i,
  input  retire_pkg::reg_addr_t [`NR_COMMIT_PORTS-1:0]  waddr_i,
  input  retire_pkg::xlen_t [`NR_COMMIT_PORTS-1:0]      wdata_i,
  input  retire_pkg::reg_addr_t                         raddr_i,
  output retire_pkg::xlen_t                             rdata_o
);
  import retire_pkg::*;

  // no storage for x0
  xlen_t regs_q [1:31];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int r = 1; r < 32; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      // higher port index written later so it wins
      for (int p = 0; p < `NR_COMMIT_PORTS; p++) begin
        if (we_i[p] && waddr_i[p] != '0) begin
          regs_q[waddr_i[p]] <= wdata_i[p];
        end
      end
    end
  end

  assign rdata_o = (raddr_i == '0) ? '0 : regs_q[raddr_i];

endmodule

/* csr_unit.sv */
/*
  mscratch, mcause, mtval only, any other address raises illegal instruction
  csr_exception_o depends on the address alone and is valid even without a write
*/
`include "retire_macros.svh"

module csr_unit (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  retire_pkg::csr_addr_t   csr_addr_i,
  input  retire_pkg::xlen_t       csr_wdata_i,
  input  logic                    csr_we_i,
  input  retire_pkg::exception_t  trap_i,
  output retire_pkg::xlen_t       csr_rdata_o,
  output retire_pkg::exception_t  csr_exception_o
);
  import retire_pkg::*;

  // illegal instruction cause code
  localparam xlen_t CAUSE_ILLEGAL = 32'd2;

  xlen_t mscratch_q;
  xlen_t mcause_q;
  xlen_t mtval_q;
  logic  illegal;

  // address decode and read mux
  always_comb begin
    csr_rdata_o = '0;
    illegal     = 1'b0;
    case (csr_addr_i)
      `CSR_MSCRATCH: csr_rdata_o = mscratch_q;
      `CSR_MCAUSE:   csr_rdata_o = mcause_q;
      `CSR_MTVAL:    csr_rdata_o = mtval_q;
      default:       illegal     = 1'b1;
    endcase
  end

  assign csr_exception_o.valid = illegal;
  assign csr_exception_o.cause = illegal ? CAUSE_ILLEGAL : '0;
  assign csr_exception_o.tval  = '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mscratch_q <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
    end else begin
      if (csr_we_i) begin
        case (csr_addr_i)
          `CSR_MSCRATCH: mscratch_q <= csr_wdata_i;
          `CSR_MCAUSE:   mcause_q   <= csr_wdata_i;
          `CSR_MTVAL:    mtval_q    <= csr_wdata_i;
          default:       mscratch_q <= mscratch_q;
        endcase
      end
      // a trap never coincides with a csr write, no ack is given then
      if (trap_i.valid) begin
        mcause_q <= trap_i.cause;
        mtval_q  <= trap_i.tval;
      end
    end
  end

endmodule

/* store_buffer.sv */
/*
  committed stores drained in order as single wishbone classic word writes
  one idle bus cycle follows every ack, SB_DEPTH must be a power of two
*/
`include "retire_macros.svh"

module store_buffer (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      commit_lsu_i,
  input  retire_pkg::store_entry_t  store_i,
  output logic                      lsu_ready_o,
  output logic                      no_st_pending_o,
  output wb_pkg::wb_req_t           wb_req_o,
  input  wb_pkg::wb_rsp_t           wb_rsp_i
);
  import retire_pkg::*;
  import wb_pkg::*;

  localparam int unsigned PTR_W = $clog2(`SB_DEPTH);

  typedef enum logic [1:0] {
    SB_IDLE,
    SB_BUS,
    SB_GAP
  } sb_state_t;

  store_entry_t     mem_q [`SB_DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W:0]   count_q;
  sb_state_t        state_q;
  sb_state_t        state_d;
  logic             push;
  logic             pop;
  logic             bus_active;

  assign lsu_ready_o     = (count_q != `SB_DEPTH);
  // drained and bus quiet
  assign no_st_pending_o = (count_q == '0) && (state_q == SB_IDLE);
  assign push            = commit_lsu_i & lsu_ready_o;
  assign bus_active      = (state_q == SB_BUS);
  // entry leaves when the slave acks
  assign pop             = bus_active & wb_rsp_i.ack;

  // ------------------------------
  // wishbone request
  // ------------------------------
  // head entry stays put while the cycle is open, so adr and dat are stable
  assign wb_req_o.cyc = bus_active;
  assign wb_req_o.stb = bus_active;
  assign wb_req_o.we  = bus_active;
  assign wb_req_o.sel = bus_active ? '1 : '0;
  assign wb_req_o.adr = wb_addr_t'(mem_q[rd_ptr_q].addr);
  assign wb_req_o.dat = mem_q[rd_ptr_q].data;

  // bus FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      SB_IDLE: begin
        if (count_q != '0) begin
          state_d = SB_BUS;
        end
      end
      SB_BUS: begin
        if (wb_rsp_i.ack) begin
          state_d = SB_GAP;
        end
      end
      // one dead cycle, then straight into the next write
      SB_GAP: begin
        state_d = (count_q != '0) ? SB_BUS : SB_IDLE;
      end
      default: begin
        state_d = SB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= SB_IDLE;
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      state_q  <= state_d;
      rd_ptr_q <= rd_ptr_q + PTR_W'(pop);
      wr_ptr_q <= wr_ptr_q + PTR_W'(push);
      count_q  <= count_q + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= store_i;
    end
  end

endmodule

/* retire_top.sv */
/*
  retirement subsystem, queue to commit stage to regfile, csrs and store buffer
  exception_o is reported only, nothing redirects fetch
*/
`include "retire_macros.svh"

module retire_top (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      halt_i,
  input  logic                      dispatch_valid_i,
  input  retire_pkg::commit_entry_t dispatch_entry_i,
  output logic                      dispatch_ready_o,
  input  retire_pkg::reg_addr_t     rf_raddr_i,
  output retire_pkg::xlen_t         rf_rdata_o,
  output retire_pkg::exception_t    exception_o,
  output retire_pkg::trans_id_t     commit_tran_id_o,
  output wb_pkg::wb_req_t           wb_req_o,
  input  wb_pkg::wb_rsp_t           wb_rsp_i
);
  import retire_pkg::*;

  // ------------------------------
  // interconnect
  // ------------------------------
  commit_entry_t [`NR_COMMIT_PORTS-1:0] head_entry;
  logic [`NR_COMMIT_PORTS-1:0]          head_valid;
  logic [`NR_COMMIT_PORTS-1:0]          commit_ack;
  logic [`NR_COMMIT_PORTS-1:0]          rf_we;
  reg_addr_t [`NR_COMMIT_PORTS-1:0]     rf_waddr;
  xlen_t [`NR_COMMIT_PORTS-1:0]         rf_wdata;
  csr_addr_t                            csr_addr;
  xlen_t                                csr_wdata;
  xlen_t                                csr_rdata;
  logic                                 csr_we;
  exception_t                           csr_exception;
  logic                                 commit_lsu;
  store_entry_t                         store;
  logic                                 lsu_ready;
  logic                                 no_st_pending;

  reorder_queue reorder_queue_i (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .flush_i          (exception_o.valid),
    .dispatch_valid_i (dispatch_valid_i),
    .dispatch_entry_i (dispatch_entry_i),
    .dispatch_ready_o (dispatch_ready_o),
    .commit_ack_i     (commit_ack),
    .head_valid_o     (head_valid),
    .head_entry_o     (head_entry)
  );

  commit_stage commit_stage_i (
    .clk_i            (clk_i),
    .halt_i           (halt_i),
    .commit_entry_i   (head_entry),
    .commit_valid_i   (head_valid),
    .commit_ack_o     (commit_ack),
    .we_o             (rf_we),
    .waddr_o          (rf_waddr),
    .wdata_o          (rf_wdata),
    .csr_addr_o       (csr_addr),
    .csr_wdata_o      (csr_wdata),
    .csr_we_o         (csr_we),
    .csr_rdata_i      (csr_rdata),
    .csr_exception_i  (csr_exception),
    .commit_lsu_o     (commit_lsu),
    .store_o          (store),
    .lsu_ready_i      (lsu_ready),
    .no_st_pending_i  (no_st_pending),
    .exception_o      (exception_o),
    .commit_tran_id_o (commit_tran_id_o)
  );

  reg_file reg_file_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

  // trap record taken straight from the selected exception
  csr_unit csr_unit_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .csr_addr_i      (csr_addr),
    .csr_wdata_i     (csr_wdata),
    .csr_we_i        (csr_we),
    .trap_i          (exception_o),
    .csr_rdata_o     (csr_rdata),
    .csr_exception_o (csr_exception)
  );

  store_buffer store_buffer_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .commit_lsu_i    (commit_lsu),
    .store_i         (store),
    .lsu_ready_o     (lsu_ready),
    .no_st_pending_o (no_st_pending),
    .wb_req_o        (wb_req_o),
    .wb_rsp_i        (wb_rsp_i)
  );

endmodule

/* tb_retire_top.sv */
/*
  halt is held during dispatch so a whole batch sits in the queue of retire_top
  a batch holds at most RQ_DEPTH entries, including the x31 marker entry
*/
`include "retire_macros.svh"

module tb_retire_top;
  timeunit 1ns;
  timeprecision 1ps;
  import retire_pkg::*;
  import wb_pkg::*;

  localparam int TIMEOUT = 300;

  logic          clk_i;
  logic          rst_i;
  logic          halt_i;
  logic          dispatch_valid_i;
  commit_entry_t dispatch_entry_i;
  logic          dispatch_ready_o;
  reg_addr_t     rf_raddr_i;
  xlen_t         rf_rdata_o;
  exception_t    exception_o;
  trans_id_t     commit_tran_id_o;
  wb_req_t       wb_req_o;
  wb_rsp_t       wb_rsp_i;

  // reference state
  xlen_t         model_regs [32];
  xlen_t         model_mem [256];
  xlen_t         model_mscratch;
  xlen_t         model_mcause;
  xlen_t         model_mtval;
  int            model_writes;
  trans_id_t     model_ex_tid;
  commit_entry_t prog [$];
  trans_id_t     next_tid;

  // memory model state
  xlen_t         mem [256];
  int            mem_writes;
  logic          busy;
  logic          ack_next;
  int            wait_left;
  wb_addr_t      hold_adr;
  xlen_t         hold_dat;
  integer        seed = 32'hc519;

  exception_t    ex_seen;
  trans_id_t     tid_seen;
  int            ex_cycles;
  int            errors;
  int            tests;
  int            errs_at_start;

  retire_top retire_top_i (.*);

  always #5 clk_i = ~clk_i;

  // ------------------------------
  // wishbone memory model
  // ------------------------------
  always @(posedge clk_i) begin : memory_model
    int d;
    if (rst_i) begin
      busy     = 1'b0;
      ack_next = 1'b0;
    end else if (wb_req_o.cyc && wb_req_o.stb) begin
      // adr and dat must hold for the whole cycle
      if (busy && (wb_req_o.adr != hold_adr || wb_req_o.dat != hold_dat)) begin
        $display("error at %0t ns: wishbone adr or dat changed before ack", $time);
        errors++;
      end
      if (!wb_req_o.we || wb_req_o.sel != 4'hf) begin
        $display("error at %0t ns: wishbone write without we or full sel", $time);
        errors++;
      end
      if (wb_rsp_i.ack) begin
        mem[wb_req_o.adr[9:2]] = wb_req_o.dat;
        mem_writes++;
        busy     = 1'b0;
        ack_next = 1'b0;
      end else if (!busy) begin
        busy      = 1'b1;
        hold_adr  = wb_req_o.adr;
        hold_dat  = wb_req_o.dat;
        d         = $random(seed) & 3;
        wait_left = d;
        ack_next  = (d == 0);
      end else begin
        wait_left--;
        ack_next = (wait_left == 0);
      end
    end else begin
      busy     = 1'b0;
      ack_next = 1'b0;
    end
    #1 wb_rsp_i.ack = ack_next;
  end

  // exception monitor samples mid-cycle
  always @(negedge clk_i) begin
    if (!rst_i && exception_o.valid) begin
      ex_seen  = exception_o;
      tid_seen = commit_tran_id_o;
      ex_cycles++;
    end
  end

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic exception_t ref_retire();
    exception_t ex;
    xlen_t      old;
    logic       legal;
    ex = '0;
    foreach (prog[i]) begin
      if (ex.valid) break;
      if (prog[i].ex.valid) begin
        ex           = prog[i].ex;
        model_ex_tid = prog[i].trans_id;
      end else begin
        case (prog[i].op)
          OP_ALU, OP_LOAD: if (prog[i].rd != 0) model_regs[prog[i].rd] = prog[i].result;
          OP_STORE: begin
            model_mem[prog[i].addr[9:2]] = prog[i].result;
            model_writes++;
          end
          OP_CSRRW: begin
            legal = 1'b1;
            old   = '0;
            case (prog[i].addr[11:0])
              `CSR_MSCRATCH: begin
                old            = model_mscratch;
                model_mscratch = prog[i].result;
              end
              `CSR_MCAUSE: begin
                old          = model_mcause;
                model_mcause = prog[i].result;
              end
              `CSR_MTVAL: begin
                old         = model_mtval;
                model_mtval = prog[i].result;
              end
              default: legal = 1'b0;
            endcase
            if (!legal) begin
              // illegal instruction takes tval from the entry
              ex.valid     = 1'b1;
              ex.cause     = 32'd2;
              ex.tval      = prog[i].ex.tval;
              model_ex_tid = prog[i].trans_id;
            end else if (prog[i].rd != 0) begin
              model_regs[prog[i].rd] = old;
            end
          end
          default: ;
        endcase
      end
    end
    if (ex.valid) begin
      model_mcause = ex.cause;
      model_mtval  = ex.tval;
    end
    return ex;
  endfunction

  function automatic commit_entry_t make_entry(instr_op_t op, reg_addr_t rd, xlen_t result,
                                               xlen_t addr);
    commit_entry_t e;
    e          = '0;
    e.op       = op;
    e.rd       = rd;
    e.result   = result;
    e.addr     = addr;
    e.trans_id = next_tid;
    next_tid++;
    return e;
  endfunction

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_xlen(input string what, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_trans_id(input string what, input trans_id_t got, input trans_id_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_exception(input string what, input exception_t got, input exception_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s got v%b cause %h tval %h expected v%b cause %h tval %h",
               $time, what, got.valid, got.cause, got.tval, exp.valid, exp.cause, exp.tval);
      errors++;
    end
  endtask

  task automatic abort(input string why);
    $display("timeout: %s", why);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  // tasks start and end 1 ns after a rising edge
  task automatic read_reg(input reg_addr_t r, output xlen_t v);
    rf_raddr_i = r;
    @(negedge clk_i);
    v = rf_rdata_o;
    @(posedge clk_i);
    #1;
  endtask

  task automatic dispatch(input commit_entry_t e);
    int t;
    dispatch_entry_i = e;
    dispatch_valid_i = 1'b1;
    t = 0;
    while (1) begin
      @(negedge clk_i);
      if (dispatch_ready_o) break;
      if (++t > TIMEOUT) abort("dispatch_ready_o never came back");
    end
    @(posedge clk_i);
    #1;
    dispatch_valid_i = 1'b0;
  endtask

  task automatic compare_state();
    xlen_t v;
    for (int r = 0; r < 32; r++) begin
      read_reg(r, v);
      check_xlen($sformatf("x%0d", r), v, model_regs[r]);
    end
    for (int a = 0; a < 256; a++) begin
      check_xlen($sformatf("mem word %0d", a), mem[a], model_mem[a]);
    end
  endtask

  task automatic run_batch(input xlen_t marker, input bit expect_ex, input bit fence_check,
                           input int hold);
    xlen_t      v;
    xlen_t      old31;
    exception_t exp_ex;
    int         ex_before;
    int         t;
    halt_i = 1'b1;
    if (!expect_ex) prog.push_back(make_entry(OP_ALU, 5'd31, marker, '0));
    foreach (prog[i]) dispatch(prog[i]);
    old31     = model_regs[31];
    ex_before = ex_cycles;
    exp_ex    = ref_retire();
    prog.delete();
    // nothing may retire while halted, the marker shows it in marker batches
    repeat (hold) begin
      read_reg(5'd31, v);
      if (!expect_ex) check_xlen("x31 under halt", v, old31);
    end
    if (ex_cycles != ex_before) begin
      $display("exception reported while halt was high");
      errors++;
    end
    halt_i = 1'b0;
    t = 0;
    if (expect_ex) begin
      while (ex_cycles == ex_before) begin
        @(posedge clk_i);
        #1;
        if (++t > TIMEOUT) abort("exception_o never went valid");
      end
      check_exception("exception_o", ex_seen, exp_ex);
      check_trans_id("commit_tran_id_o", tid_seen, model_ex_tid);
      repeat (3) @(posedge clk_i);
      #1;
      if (ex_cycles != ex_before + 1) begin
        $display("exception_o valid for %0d cycles instead of one", ex_cycles - ex_before);
        errors++;
      end
    end else begin
      v = old31;
      while (v !== marker) begin
        read_reg(5'd31, v);
        if (++t > TIMEOUT) abort("marker entry never retired");
      end
      // a fence ahead of the marker means all stores already landed
      if (fence_check && mem_writes != model_writes) begin
        $display("error at %0t ns: entry after fence retired with %0d of %0d stores done",
                 $time, mem_writes, model_writes);
        errors++;
      end
      t = 0;
      while (mem_writes != model_writes) begin
        @(posedge clk_i);
        #1;
        if (++t > TIMEOUT) abort("stores never reached memory");
      end
    end
    compare_state();
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == errs_at_start) $display("test %s: ok", name);
    else $display("test %s: %0d mismatches", name, errors - errs_at_start);
    errs_at_start = errors;
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    commit_entry_t e;
    clk_i = 1'b0;
    rst_i = 1'b1;
    halt_i = 1'b0;
    dispatch_valid_i = 1'b0;
    dispatch_entry_i = '0;
    rf_raddr_i = '0;
    wb_rsp_i = '0;
    errors = 0;
    tests = 0;
    errs_at_start = 0;
    ex_cycles = 0;
    mem_writes = 0;
    model_writes = 0;
    model_ex_tid = '0;
    next_tid = '0;
    model_mscratch = '0;
    model_mcause = '0;
    model_mtval = '0;
    for (int r = 0; r < 32; r++) model_regs[r] = '0;
    // fill pattern over the whole word address
    for (int a = 0; a < 256; a++) begin
      mem[a]       = 32'h5a00_0000 ^ (a * 32'h0001_0101);
      model_mem[a] = mem[a];
    end
    repeat (10) @(posedge clk_i);
    #1 rst_i = 1'b0;

    // burst with dual commits, same-rd pair and a write to x0
    prog.push_back(make_entry(OP_ALU, 5'd1, $random(seed), '0));
    prog.push_back(make_entry(OP_LOAD, 5'd2, $random(seed), '0));
    prog.push_back(make_entry(OP_ALU, 5'd3, $random(seed), '0));
    prog.push_back(make_entry(OP_ALU, 5'd3, $random(seed), '0));
    prog.push_back(make_entry(OP_ALU, 5'd0, 32'hffff_ffff, '0));
    prog.push_back(make_entry(OP_LOAD, 5'd4, $random(seed), '0));
    prog.push_back(make_entry(OP_ALU, 5'd4, $random(seed), '0));
    run_batch(32'ha000_0001, 1'b0, 1'b0, 2);
    end_test("alu_load_burst");

    // stores between alu entries
    prog.push_back(make_entry(OP_ALU, 5'd5, $random(seed), '0));
    prog.push_back(make_entry(OP_STORE, 5'd9, $random(seed), 32'h10));
    prog.push_back(make_entry(OP_STORE, 5'd0, $random(seed), 32'h3fc));
    prog.push_back(make_entry(OP_ALU, 5'd6, $random(seed), '0));
    prog.push_back(make_entry(OP_STORE, 5'd0, $random(seed), 32'h14));
    prog.push_back(make_entry(OP_STORE, 5'd0, $random(seed), 32'h10));
    prog.push_back(make_entry(OP_STORE, 5'd0, $random(seed), 32'h200));
    run_batch(32'ha000_0002, 1'b0, 1'b0, 2);
    end_test("stores");

    // csrrw swaps through mscratch and a fence sits behind two stores
    prog.push_back(make_entry(OP_CSRRW, 5'd7, 32'h1111_2222, `CSR_MSCRATCH));
    prog.push_back(make_entry(OP_CSRRW, 5'd8, 32'h3333_4444, `CSR_MSCRATCH));
    prog.push_back(make_entry(OP_STORE, 5'd0, 32'hcafe_0001, 32'h40));
    prog.push_back(make_entry(OP_STORE, 5'd0, 32'hcafe_0002, 32'h44));
    prog.push_back(make_entry(OP_FENCE, 5'd0, '0, '0));
    run_batch(32'ha000_0003, 1'b0, 1'b1, 2);
    end_test("csrrw_fence");

    // flagged entry flushes the younger one
    prog.push_back(make_entry(OP_ALU, 5'd10, 32'h0000_00aa, '0));
    e          = make_entry(OP_LOAD, 5'd11, 32'h0000_00bb, '0);
    e.ex.valid = 1'b1;
    e.ex.cause = 32'd5;
    e.ex.tval  = 32'h0000_1234;
    prog.push_back(e);
    prog.push_back(make_entry(OP_ALU, 5'd12, 32'h0000_00cc, '0));
    run_batch('0, 1'b1, 1'b0, 2);
    prog.push_back(make_entry(OP_CSRRW, 5'd13, '0, `CSR_MCAUSE));
    prog.push_back(make_entry(OP_CSRRW, 5'd14, '0, `CSR_MTVAL));
    run_batch(32'ha000_0004, 1'b0, 1'b0, 2);
    end_test("entry_exception");

    // csr address outside the map
    e         = make_entry(OP_CSRRW, 5'd1, 32'h9999_9999, 32'h7c0);
    e.ex.tval = 32'h0000_dead;
    prog.push_back(e);
    run_batch('0, 1'b1, 1'b0, 2);
    end_test("illegal_csr");

    // long halt followed by release
    prog.push_back(make_entry(OP_ALU, 5'd15, $random(seed), '0));
    prog.push_back(make_entry(OP_STORE, 5'd0, $random(seed), 32'h80));
    prog.push_back(make_entry(OP_LOAD, 5'd16, $random(seed), '0));
    run_batch(32'ha000_0006, 1'b0, 1'b0, 20);
    end_test("halt");

    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+.
retire_pkg.sv
wb_pkg.sv
reorder_queue.sv
commit_stage.sv
reg_file.sv
csr_unit.sv
store_buffer.sv
retire_top.sv
tb_retire_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_retire_top
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep '\.sv$$' $(FLIST))
HDRS := retire_macros.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
